/* hw/ttlBridgePkg.sv */
`default_nettype none

package ttlBridgePkg;

  // Bus widths
  localparam int MST_AWIDTH  = 32;
  localparam int MST_DWIDTH  = 32;
  localparam int TTL_DWIDTH  = 8;
  localparam int MST_BEWIDTH = MST_DWIDTH / 8;

  // Per-port access sequencer
  typedef enum logic [2:0] {
    Idle,
    Capture,
    WaitCredit,
    WaitResp,
    Drive,
    Release
  } bridgeState_e;

  typedef enum logic {
    OpRead,
    OpWrite
  } mstOp_e;

  // Configuration register map, base of port n sits at REG_BASE0 + n
  localparam logic [3:0] REG_INTR_STATUS = 4'd0;
  localparam logic [3:0] REG_INTR_ENABLE = 4'd1;
  localparam logic [3:0] REG_BASE0       = 4'd2;

  // Status layout, three bits per port
  localparam int STATUS_BITS  = 3;
  localparam int STAT_READ    = 0;
  localparam int STAT_WRITE   = 1;
  localparam int STAT_ERROR   = 2;

endpackage

`default_nettype wire

/* hw/ttlWindowRegs.sv */
`default_nettype none

module ttlWindowRegs #(
  parameter int NUM_PORTS = 2
) (
  input  logic                                clk,
  input  logic                                rst_n,
  input  logic                                cfgWrite,
  input  logic [3:0]                          cfgAddr,
  input  logic [ttlBridgePkg::MST_DWIDTH-1:0] cfgWrData,
  output logic [ttlBridgePkg::MST_DWIDTH-1:0] cfgRdData,
  input  logic [NUM_PORTS-1:0]                evtRead,
  input  logic [NUM_PORTS-1:0]                evtWrite,
  input  logic [NUM_PORTS-1:0]                evtError,
  output logic [ttlBridgePkg::MST_AWIDTH-1:0] portBase [NUM_PORTS],
  output logic                                interrupt
);
  import ttlBridgePkg::*;

  localparam int STAT_W = STATUS_BITS * NUM_PORTS;

  logic [STAT_W-1:0] intrStatus;
  logic [STAT_W-1:0] intrEnable;
  logic [STAT_W-1:0] setMask;
  logic [STAT_W-1:0] clrMask;

  // Write one to clear
  assign clrMask = (cfgWrite && cfgAddr == REG_INTR_STATUS) ? cfgWrData[STAT_W-1:0] : '0;

  always_comb begin
    setMask = '0;
    for (int i = 0; i < NUM_PORTS; i++) begin
      setMask[STATUS_BITS*i + STAT_READ]  = evtRead[i];
      setMask[STATUS_BITS*i + STAT_WRITE] = evtWrite[i];
      setMask[STATUS_BITS*i + STAT_ERROR] = evtError[i];
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      intrStatus <= '0;
      intrEnable <= '0;
      for (int i = 0; i < NUM_PORTS; i++) begin
        portBase[i] <= '0;
      end
    end else begin
      // A set in the same cycle as a clear wins
      intrStatus <= (intrStatus & ~clrMask) | setMask;
      if (cfgWrite && cfgAddr == REG_INTR_ENABLE) begin
        intrEnable <= cfgWrData[STAT_W-1:0];
      end
      for (int i = 0; i < NUM_PORTS; i++) begin
        if (cfgWrite && cfgAddr == REG_BASE0 + 4'(i)) begin
          portBase[i] <= cfgWrData[MST_AWIDTH-1:0];
        end
      end
    end
  end

  always_comb begin
    cfgRdData = '0;
    if (cfgAddr == REG_INTR_STATUS) begin
      cfgRdData[STAT_W-1:0] = intrStatus;
    end else if (cfgAddr == REG_INTR_ENABLE) begin
      cfgRdData[STAT_W-1:0] = intrEnable;
    end
    for (int i = 0; i < NUM_PORTS; i++) begin
      if (cfgAddr == REG_BASE0 + 4'(i)) cfgRdData = portBase[i];
    end
  end

  assign interrupt = |(intrStatus & intrEnable);

  // Bridge events are single-cycle pulses
  for (genvar b = 0; b < STAT_W; b++) begin : gStatusChk
    assert property (@(posedge clk) disable iff (!rst_n)
      setMask[b] |=> !setMask[b]);
  end

endmodule

`default_nettype wire

/* hw/ttlPortBridge.sv */
`default_nettype none

module ttlPortBridge #(
  parameter int ADDR_WIDTH = 16
) (
  input  logic                                clk,
  input  logic                                rst_n,
  input  logic                                nChipEnable,
  input  logic                                nOutputEnable,
  input  logic                                nWriteEnable,
  input  logic [ADDR_WIDTH-1:0]               address,
  input  logic [ttlBridgePkg::TTL_DWIDTH-1:0] dataIn,
  output logic [ttlBridgePkg::TTL_DWIDTH-1:0] dataOut,
  output logic                                dataOe,
  output logic                                nWait,
  input  logic [ttlBridgePkg::MST_AWIDTH-1:0] portBase,
  output logic                                reqValid,
  output ttlBridgePkg::mstOp_e                reqOp,
  output logic [ttlBridgePkg::MST_AWIDTH-1:0] reqAddr,
  output logic [ttlBridgePkg::TTL_DWIDTH-1:0] reqWrData,
  input  logic                                credit,
  input  logic                                rspValid,
  input  logic [ttlBridgePkg::TTL_DWIDTH-1:0] rspData,
  input  logic                                rspError,
  output logic                                evtRead,
  output logic                                evtWrite,
  output logic                                evtError
);
  import ttlBridgePkg::*;

  logic [2:0]            ctrlMeta;
  logic [2:0]            ctrlSync;
  logic                  ceActive;
  logic                  oeActive;
  logic                  weActive;
  logic                  accessStart;
  logic                  spend;
  logic                  rspTaken;
  bridgeState_e          state;
  mstOp_e                opReg;
  logic [ADDR_WIDTH-1:0] addrReg;
  logic [TTL_DWIDTH-1:0] wrByte;
  logic [TTL_DWIDTH-1:0] rdByte;
  logic [MST_AWIDTH-1:0] mappedAddr;
  logic [1:0]            creditCnt;

  // Two-flop synchronizer on CE, OE, WE, idling at the inactive level
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      ctrlMeta <= 3'b111;
      ctrlSync <= 3'b111;
    end else begin
      ctrlMeta <= {nChipEnable, nOutputEnable, nWriteEnable};
      ctrlSync <= ctrlMeta;
    end
  end

  assign ceActive    = !ctrlSync[2];
  assign oeActive    = !ctrlSync[1];
  assign weActive    = !ctrlSync[0];
  assign accessStart = ceActive && (oeActive || weActive);

  assign spend    = (state == WaitCredit) && (creditCnt != 2'd0);
  assign rspTaken = (state == WaitResp) && rspValid;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state <= Idle;
    end else begin
      case (state)
        Idle: begin
          if (accessStart) state <= Capture;
        end
        Capture: state <= WaitCredit;
        WaitCredit: begin
          if (spend) state <= WaitResp;
        end
        WaitResp: begin
          if (rspValid) state <= Drive;
        end
        // Hold the result until the host lets go of chip enable
        Drive: begin
          if (!ceActive) state <= Release;
        end
        Release: state <= Idle;
        default: state <= Idle;
      endcase
    end
  end

  // Address, data and direction are sampled once the controls are settled
  always_ff @(posedge clk) begin
    if (state == Idle && accessStart) begin
      addrReg <= address;
      wrByte  <= dataIn;
      opReg   <= weActive ? OpWrite : OpRead;
    end
    if (state == Capture) begin
      mappedAddr <= portBase + MST_AWIDTH'(addrReg);
    end
    // A write leaves its own byte readable afterwards
    if (rspTaken) begin
      rdByte <= (opReg == OpRead) ? rspData : wrByte;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      creditCnt <= 2'd1;
    end else begin
      creditCnt <= creditCnt + {1'b0, credit} - {1'b0, spend};
    end
  end

  assign reqValid  = spend;
  assign reqOp     = opReg;
  assign reqAddr   = mappedAddr;
  assign reqWrData = wrByte;

  assign nWait   = !(state inside {Capture, WaitCredit, WaitResp});
  assign dataOut = rdByte;
  // Pad enable follows the raw pins so the bus turns around without sync delay
  assign dataOe  = (state == Drive) && !nChipEnable && !nOutputEnable && nWriteEnable;

  assign evtRead  = rspTaken && !rspError && (opReg == OpRead);
  assign evtWrite = rspTaken && !rspError && (opReg == OpWrite);
  assign evtError = rspTaken && rspError;

  // Spending the credit empties it, and it cannot come back in the same cycle
  assert property (@(posedge clk) disable iff (!rst_n)
    reqValid |-> (creditCnt == 2'd1) ##1 (creditCnt == 2'd0));

  // Arbiter never returns more credit than was spent
  assert property (@(posedge clk) disable iff (!rst_n) creditCnt <= 2'd1);

endmodule

`default_nettype wire

/* hw/busMasterArbiter.sv */
`default_nettype none

module busMasterArbiter #(
  parameter int NUM_PORTS = 2
) (
  input  logic                                 clk,
  input  logic                                 rst_n,
  input  logic [NUM_PORTS-1:0]                 reqValid,
  input  ttlBridgePkg::mstOp_e                 reqOp     [NUM_PORTS],
  input  logic [ttlBridgePkg::MST_AWIDTH-1:0]  reqAddr   [NUM_PORTS],
  input  logic [ttlBridgePkg::TTL_DWIDTH-1:0]  reqWrData [NUM_PORTS],
  output logic [NUM_PORTS-1:0]                 credit,
  output logic [NUM_PORTS-1:0]                 rspValid,
  output logic [ttlBridgePkg::TTL_DWIDTH-1:0]  rspData   [NUM_PORTS],
  output logic [NUM_PORTS-1:0]                 rspError,
  output logic                                 mstRdReq,
  output logic                                 mstWrReq,
  output logic [ttlBridgePkg::MST_AWIDTH-1:0]  mstAddr,
  output logic [ttlBridgePkg::MST_BEWIDTH-1:0] mstBe,
  output logic [ttlBridgePkg::MST_DWIDTH-1:0]  mstWrData,
  input  logic                                 mstCmdAck,
  input  logic                                 mstCmplt,
  input  logic                                 mstError,
  input  logic [ttlBridgePkg::MST_DWIDTH-1:0]  mstRdData
);
  import ttlBridgePkg::*;

  localparam int PORT_W = (NUM_PORTS > 1) ? $clog2(NUM_PORTS) : 1;

  typedef enum logic [2:0] {ArbIdle, ArbCmd, ArbData, ArbResp, ArbCredit} arbState_e;

  arbState_e             state;
  logic [NUM_PORTS-1:0]  slotValid;
  mstOp_e                slotOp   [NUM_PORTS];
  logic [MST_AWIDTH-1:0] slotAddr [NUM_PORTS];
  logic [TTL_DWIDTH-1:0] slotData [NUM_PORTS];
  logic [PORT_W-1:0]     grant;
  logic [PORT_W-1:0]     pick;
  logic                  pickValid;
  logic                  done;
  logic [1:0]            laneSel;
  logic [TTL_DWIDTH-1:0] rspByte;
  logic                  rspErr;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      slotValid <= '0;
    end else begin
      for (int i = 0; i < NUM_PORTS; i++) begin
        if (reqValid[i]) slotValid[i] <= 1'b1;
        else if (credit[i]) slotValid[i] <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    for (int i = 0; i < NUM_PORTS; i++) begin
      if (reqValid[i]) begin
        slotOp[i]   <= reqOp[i];
        slotAddr[i] <= reqAddr[i];
        slotData[i] <= reqWrData[i];
      end
    end
  end

  // Search starts just after the port granted last
  always_comb begin
    int idx;
    pickValid = 1'b0;
    pick      = grant;
    for (int k = 1; k <= NUM_PORTS; k++) begin
      idx = (int'(grant) + k) % NUM_PORTS;
      if (!pickValid && slotValid[idx]) begin
        pickValid = 1'b1;
        pick      = PORT_W'(idx);
      end
    end
  end

  assign done = (state == ArbData || (state == ArbCmd && mstCmdAck)) && mstCmplt;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state <= ArbIdle;
      grant <= PORT_W'(NUM_PORTS - 1);
    end else begin
      case (state)
        ArbIdle: begin
          if (pickValid) begin
            grant <= pick;
            state <= ArbCmd;
          end
        end
        ArbCmd: begin
          if (mstCmdAck) state <= mstCmplt ? ArbResp : ArbData;
        end
        ArbData: begin
          if (mstCmplt) state <= ArbResp;
        end
        ArbResp: state <= ArbCredit;
        default: state <= ArbIdle;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (done) begin
      rspByte <= mstRdData[{laneSel, 3'b000} +: TTL_DWIDTH];
      rspErr  <= mstError;
    end
  end

  assign laneSel   = slotAddr[grant][1:0];
  assign mstAddr   = slotAddr[grant];
  assign mstBe     = MST_BEWIDTH'(1) << laneSel;
  assign mstWrData = {(MST_DWIDTH / TTL_DWIDTH){slotData[grant]}};
  assign mstRdReq  = (state == ArbCmd) && (slotOp[grant] == OpRead);
  assign mstWrReq  = (state == ArbCmd) && (slotOp[grant] == OpWrite);

  // Response first, the slot goes back one cycle later
  always_comb begin
    for (int i = 0; i < NUM_PORTS; i++) begin
      rspValid[i] = (state == ArbResp) && (grant == PORT_W'(i));
      credit[i]   = (state == ArbCredit) && (grant == PORT_W'(i));
      rspData[i]  = rspByte;
      rspError[i] = rspErr;
    end
  end

  assert property (@(posedge clk) disable iff (!rst_n) !(mstRdReq && mstWrReq));

  // Bridges only send with a credit in hand, so a slot is free on arrival
  for (genvar p = 0; p < NUM_PORTS; p++) begin : gSlotChk
    assert property (@(posedge clk) disable iff (!rst_n) reqValid[p] |-> !slotValid[p]);
  end

endmodule

`default_nettype wire

/* hw/ttlBridgeTop.sv */
`default_nettype none

module ttlBridgeTop #(
  parameter int NUM_PORTS  = 2,
  parameter int ADDR_WIDTH = 16
) (
  input  logic                                 clk,
  input  logic                                 rst_n,
  input  logic [NUM_PORTS-1:0]                 nChipEnable,
  input  logic [NUM_PORTS-1:0]                 nOutputEnable,
  input  logic [NUM_PORTS-1:0]                 nWriteEnable,
  input  logic [ADDR_WIDTH-1:0]                address [NUM_PORTS],
  input  logic [ttlBridgePkg::TTL_DWIDTH-1:0]  dataIn  [NUM_PORTS],
  output logic [ttlBridgePkg::TTL_DWIDTH-1:0]  dataOut [NUM_PORTS],
  output logic [NUM_PORTS-1:0]                 dataOe,
  output logic [NUM_PORTS-1:0]                 nWait,
  input  logic                                 cfgWrite,
  input  logic [3:0]                           cfgAddr,
  input  logic [ttlBridgePkg::MST_DWIDTH-1:0]  cfgWrData,
  output logic [ttlBridgePkg::MST_DWIDTH-1:0]  cfgRdData,
  output logic                                 interrupt,
  output logic                                 mstRdReq,
  output logic                                 mstWrReq,
  output logic [ttlBridgePkg::MST_AWIDTH-1:0]  mstAddr,
  output logic [ttlBridgePkg::MST_BEWIDTH-1:0] mstBe,
  output logic [ttlBridgePkg::MST_DWIDTH-1:0]  mstWrData,
  input  logic                                 mstCmdAck,
  input  logic                                 mstCmplt,
  input  logic                                 mstError,
  input  logic [ttlBridgePkg::MST_DWIDTH-1:0]  mstRdData
);
  import ttlBridgePkg::*;

  logic [MST_AWIDTH-1:0] portBase  [NUM_PORTS];
  logic [NUM_PORTS-1:0]  evtRead;
  logic [NUM_PORTS-1:0]  evtWrite;
  logic [NUM_PORTS-1:0]  evtError;
  logic [NUM_PORTS-1:0]  reqValid;
  mstOp_e                reqOp     [NUM_PORTS];
  logic [MST_AWIDTH-1:0] reqAddr   [NUM_PORTS];
  logic [TTL_DWIDTH-1:0] reqWrData [NUM_PORTS];
  logic [NUM_PORTS-1:0]  credit;
  logic [NUM_PORTS-1:0]  rspValid;
  logic [TTL_DWIDTH-1:0] rspData   [NUM_PORTS];
  logic [NUM_PORTS-1:0]  rspError;

  ttlWindowRegs #(.NUM_PORTS(NUM_PORTS)) u_ttlWindowRegs (
    .clk, .rst_n, .cfgWrite, .cfgAddr, .cfgWrData, .cfgRdData,
    .evtRead, .evtWrite, .evtError, .portBase, .interrupt
  );

  for (genvar i = 0; i < NUM_PORTS; i++) begin : gPort
    ttlPortBridge #(.ADDR_WIDTH(ADDR_WIDTH)) u_ttlPortBridge (
      .clk, .rst_n,
      .nChipEnable(nChipEnable[i]), .nOutputEnable(nOutputEnable[i]),
      .nWriteEnable(nWriteEnable[i]), .address(address[i]), .dataIn(dataIn[i]),
      .dataOut(dataOut[i]), .dataOe(dataOe[i]), .nWait(nWait[i]),
      .portBase(portBase[i]), .reqValid(reqValid[i]), .reqOp(reqOp[i]),
      .reqAddr(reqAddr[i]), .reqWrData(reqWrData[i]), .credit(credit[i]),
      .rspValid(rspValid[i]), .rspData(rspData[i]), .rspError(rspError[i]),
      .evtRead(evtRead[i]), .evtWrite(evtWrite[i]), .evtError(evtError[i])
    );
  end

  busMasterArbiter #(.NUM_PORTS(NUM_PORTS)) u_busMasterArbiter (
    .clk, .rst_n, .reqValid, .reqOp, .reqAddr, .reqWrData,
    .credit, .rspValid, .rspData, .rspError,
    .mstRdReq, .mstWrReq, .mstAddr, .mstBe, .mstWrData,
    .mstCmdAck, .mstCmplt, .mstError, .mstRdData
  );

endmodule

`default_nettype wire

/* testbench/tbClockGen.sv */
`default_nettype none

module tbClockGen #(
  parameter int PERIOD       = 100,
  parameter int RESET_CYCLES = 2
) (
  output logic clk,
  output logic rst_n
);
  timeunit 1ns;
  timeprecision 1ns;

  initial begin
    clk = 1'b0;
    forever #(PERIOD / 2) clk = ~clk;
  end

  // Reset is let go on a falling edge, like every other input
  initial begin
    rst_n = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
  end

endmodule

`default_nettype wire

/* testbench/tbTtlBridge.sv */
`default_nettype none

module tbTtlBridge;
  timeunit 1ns;
  timeprecision 1ns;
  import ttlBridgePkg::*;

  localparam int NUM_PORTS   = 2;
  localparam int ADDR_WIDTH  = 16;
  // Six tests of at most a few hundred cycles each leave ample margin
  localparam int CYCLE_LIMIT = 4000;
  localparam logic [31:0] BASE0    = 32'h0000_0100;
  localparam logic [31:0] BASE1    = 32'h0002_0200;
  localparam logic [31:0] BAD_BASE = 32'hF000_0000;

  logic clk;
  logic rst_n;
  logic [NUM_PORTS-1:0]  nChipEnable;
  logic [NUM_PORTS-1:0]  nOutputEnable;
  logic [NUM_PORTS-1:0]  nWriteEnable;
  logic [ADDR_WIDTH-1:0] address [NUM_PORTS];
  logic [TTL_DWIDTH-1:0] dataIn  [NUM_PORTS];
  logic [TTL_DWIDTH-1:0] dataOut [NUM_PORTS];
  logic [NUM_PORTS-1:0]  dataOe;
  logic [NUM_PORTS-1:0]  nWait;
  logic                  cfgWrite;
  logic [3:0]            cfgAddr;
  logic [31:0]           cfgWrData;
  logic [31:0]           cfgRdData;
  logic                  interrupt;
  logic                  mstRdReq;
  logic                  mstWrReq;
  logic [31:0]           mstAddr;
  logic [3:0]            mstBe;
  logic [31:0]           mstWrData;
  logic                  mstCmdAck;
  logic                  mstCmplt;
  logic                  mstError;
  logic [31:0]           mstRdData;

  // Bus model state and command log
  logic [31:0] mem [256];
  logic [31:0] cmdAddrQ [$];
  logic [3:0]  cmdBeQ [$];
  logic [31:0] cmdDataQ [$];
  bit          cmdWriteQ [$];
  int          extraAckDelay;
  integer      seed;
  int          errCount;
  int          testsRun;
  int          testsFailed;
  int          cycles;

  tbClockGen #(.PERIOD(100), .RESET_CYCLES(2)) u_clockGen (.clk, .rst_n);

  ttlBridgeTop #(.NUM_PORTS(NUM_PORTS), .ADDR_WIDTH(ADDR_WIDTH)) u_ttlBridgeTop (
    .clk, .rst_n, .nChipEnable, .nOutputEnable, .nWriteEnable, .address, .dataIn,
    .dataOut, .dataOe, .nWait, .cfgWrite, .cfgAddr, .cfgWrData, .cfgRdData, .interrupt,
    .mstRdReq, .mstWrReq, .mstAddr, .mstBe, .mstWrData,
    .mstCmdAck, .mstCmplt, .mstError, .mstRdData
  );

  function automatic logic [31:0] fillWord(logic [7:0] a);
    return {a ^ 8'h5A, a + 8'h11, ~a, a * 8'd7};
  endfunction

  function automatic logic [31:0] statusMask(int port, int kind);
    return 32'd1 << (STATUS_BITS * port + kind);
  endfunction

  function automatic logic [3:0] laneBe(logic [31:0] a);
    return 4'b0001 << a[1:0];
  endfunction

  function automatic logic [7:0] laneByte(logic [31:0] word, logic [31:0] a);
    return word[8 * a[1:0] +: 8];
  endfunction

  function automatic int portOfAddr(logic [31:0] a);
    return (a >= BASE1) ? 1 : 0;
  endfunction

  task automatic checkValue(string name, logic [31:0] got, logic [31:0] exp);
    assert (got === exp) else begin
      $display("FAIL %s got 0x%h expected 0x%h", name, got, exp);
      errCount++;
    end
  endtask

  task automatic reportProblem(string msg);
    $display("%s", msg);
    errCount++;
  endtask

  task automatic finishTest(string name, int errsBefore);
    testsRun++;
    if (errCount == errsBefore) begin
      $display("test %-14s ok", name);
    end else begin
      testsFailed++;
      $display("test %-14s failed with %0d errors", name, errCount - errsBefore);
    end
  endtask

  task automatic writeCfg(logic [3:0] addr, logic [31:0] data);
    @(negedge clk);
    cfgWrite  = 1'b1;
    cfgAddr   = addr;
    cfgWrData = data;
    @(negedge clk);
    cfgWrite  = 1'b0;
  endtask

  task automatic readCfg(logic [3:0] addr, output logic [31:0] data);
    @(negedge clk);
    cfgAddr = addr;
    #10;
    data = cfgRdData;
  endtask

  task automatic expectCfg(string name, logic [3:0] addr, logic [31:0] exp);
    logic [31:0] got;
    readCfg(addr, got);
    checkValue(name, got, exp);
  endtask

  // Pin helpers for one port, called on a falling edge
  task automatic driveRead(int port, logic [15:0] addr);
    address[port]       = addr;
    nChipEnable[port]   = 1'b0;
    nOutputEnable[port] = 1'b0;
    nWriteEnable[port]  = 1'b1;
  endtask

  task automatic driveWrite(int port, logic [15:0] addr, logic [7:0] data);
    address[port]       = addr;
    dataIn[port]        = data;
    nChipEnable[port]   = 1'b0;
    nOutputEnable[port] = 1'b1;
    nWriteEnable[port]  = 1'b0;
  endtask

  task automatic driveIdle(int port);
    nChipEnable[port]   = 1'b1;
    nOutputEnable[port] = 1'b1;
    nWriteEnable[port]  = 1'b1;
  endtask

  // Host side wait for nWait to drop and rise again
  task automatic waitAccess(int port, output bit ok);
    int n;
    n = 0;
    while (nWait[port] && n < 20) begin
      @(negedge clk);
      n++;
    end
    ok = !nWait[port];
    assert (ok) else reportProblem($sformatf("port %0d never pulled nWait low", port));
    if (!ok) return;
    n = 0;
    while (!nWait[port] && n < 400) begin
      @(negedge clk);
      n++;
    end
    ok = nWait[port];
    assert (ok) else reportProblem($sformatf("port %0d held nWait low too long", port));
  endtask

  // Bridge needs the synchronized chip enable high before a new access
  task automatic releasePorts();
    @(negedge clk);
    for (int p = 0; p < NUM_PORTS; p++) begin
      driveIdle(p);
    end
    repeat (4) @(negedge clk);
  endtask

  task automatic singleRead(int port, logic [15:0] addr, logic [31:0] base);
    logic [31:0] full;
    bit ok;
    full = base + 32'(addr);
    @(negedge clk);
    driveRead(port, addr);
    waitAccess(port, ok);
    if (ok) begin
      checkValue("dataOe", 32'(dataOe[port]), 32'd1);
      checkValue("dataOut", 32'(dataOut[port]), 32'(laneByte(mem[full[9:2]], full)));
    end
    releasePorts();
  endtask

  task automatic singleWrite(int port, logic [15:0] addr, logic [7:0] data);
    bit ok;
    @(negedge clk);
    driveWrite(port, addr, data);
    waitAccess(port, ok);
    releasePorts();
  endtask

  task automatic testReset();
    int e;
    e = errCount;
    @(negedge clk);
    checkValue("interrupt", 32'(interrupt), 32'd0);
    checkValue("dataOe", 32'(dataOe), 32'd0);
    checkValue("mstRdReq", 32'(mstRdReq), 32'd0);
    checkValue("mstWrReq", 32'(mstWrReq), 32'd0);
    checkValue("nWait", 32'(nWait), 32'h3);
    expectCfg("cfgRdData status", REG_INTR_STATUS, 32'd0);
    expectCfg("cfgRdData base0", REG_BASE0, 32'd0);
    expectCfg("cfgRdData base1", REG_BASE0 + 4'd1, 32'd0);
    finishTest("reset", e);
  endtask

  task automatic testReadTranslation();
    int e;
    e = errCount;
    writeCfg(REG_BASE0, BASE0);
    expectCfg("cfgRdData base0", REG_BASE0, BASE0);
    singleRead(0, 16'h0013, BASE0);
    checkValue("mstAddr", cmdAddrQ[$], BASE0 + 32'h13);
    checkValue("mstBe", 32'(cmdBeQ[$]), 32'(laneBe(BASE0 + 32'h13)));
    checkValue("mstWrReq", 32'(cmdWriteQ[$]), 32'd0);
    finishTest("read", e);
  endtask

  task automatic testWrite();
    int e;
    logic [31:0] full;
    e = errCount;
    full = BASE1 + 32'h46;
    writeCfg(REG_BASE0 + 4'd1, BASE1);
    singleWrite(1, 16'h0046, 8'hC3);
    checkValue("mstWrReq", 32'(cmdWriteQ[$]), 32'd1);
    checkValue("mstAddr", cmdAddrQ[$], full);
    checkValue("mstBe", 32'(cmdBeQ[$]), 32'(laneBe(full)));
    checkValue("mstWrData", cmdDataQ[$], 32'hC3C3_C3C3);
    checkValue("mem byte", 32'(laneByte(mem[full[9:2]], full)), 32'hC3);
    finishTest("write", e);
  endtask

  task automatic testInterrupts();
    int e;
    logic [31:0] expStatus;
    e = errCount;
    expStatus = statusMask(0, STAT_READ) | statusMask(1, STAT_WRITE);
    writeCfg(REG_INTR_STATUS, 32'hFFFF_FFFF);
    expectCfg("cfgRdData status", REG_INTR_STATUS, 32'd0);
    singleRead(0, 16'h0020, BASE0);
    singleWrite(1, 16'h0045, 8'h5E);
    expectCfg("cfgRdData status", REG_INTR_STATUS, expStatus);
    checkValue("interrupt", 32'(interrupt), 32'd0);
    writeCfg(REG_INTR_ENABLE, statusMask(1, STAT_WRITE));
    #10;
    checkValue("interrupt", 32'(interrupt), 32'd1);
    // Enabled bit that never fired
    writeCfg(REG_INTR_ENABLE, statusMask(0, STAT_ERROR));
    #10;
    checkValue("interrupt", 32'(interrupt), 32'd0);
    writeCfg(REG_INTR_STATUS, statusMask(0, STAT_READ));
    expectCfg("cfgRdData status", REG_INTR_STATUS, statusMask(1, STAT_WRITE));
    writeCfg(REG_INTR_STATUS, statusMask(1, STAT_WRITE));
    expectCfg("cfgRdData status", REG_INTR_STATUS, 32'd0);
    writeCfg(REG_INTR_ENABLE, 32'd0);
    finishTest("interrupts", e);
  endtask

  task automatic testConcurrency();
    int e;
    int first;
    int n;
    logic [15:0] a0;
    logic [15:0] a1;
    logic [31:0] f0;
    logic [31:0] f1;
    e = errCount;
    first = cmdAddrQ.size();
    extraAckDelay = 6;
    for (int r = 0; r < 2; r++) begin
      a0 = 16'h0024 + 16'(r * 5);
      a1 = 16'h0031 + 16'(r * 7);
      f0 = BASE0 + 32'(a0);
      f1 = BASE1 + 32'(a1);
      @(negedge clk);
      driveRead(0, a0);
      driveRead(1, a1);
      n = 0;
      while (nWait != 2'b00 && n < 20) begin
        @(negedge clk);
        n++;
      end
      checkValue("nWait", 32'(nWait), 32'h0);
      n = 0;
      while (nWait != 2'b11 && n < 400) begin
        @(negedge clk);
        n++;
      end
      assert (nWait == 2'b11) else reportProblem("concurrent reads never released nWait");
      checkValue("dataOut[0]", 32'(dataOut[0]), 32'(laneByte(mem[f0[9:2]], f0)));
      checkValue("dataOut[1]", 32'(dataOut[1]), 32'(laneByte(mem[f1[9:2]], f1)));
      releasePorts();
    end
    extraAckDelay = 0;
    checkValue("command count", 32'(cmdAddrQ.size() - first), 32'd4);
    // The first command must also move on from the port served last
    for (int i = first; i < cmdAddrQ.size(); i++) begin
      assert (portOfAddr(cmdAddrQ[i]) != portOfAddr(cmdAddrQ[i - 1])) else begin
        reportProblem($sformatf("command %0d went to the same port twice in a row", i));
      end
    end
    finishTest("concurrency", e);
  endtask

  task automatic testError();
    int e;
    bit ok;
    e = errCount;
    writeCfg(REG_BASE0 + 4'd1, BAD_BASE);
    writeCfg(REG_INTR_STATUS, 32'hFFFF_FFFF);
    @(negedge clk);
    driveRead(1, 16'h0008);
    waitAccess(1, ok);
    checkValue("nWait", 32'(nWait[1]), 32'd1);
    expectCfg("cfgRdData status", REG_INTR_STATUS, statusMask(1, STAT_ERROR));
    releasePorts();
    writeCfg(REG_INTR_STATUS, 32'hFFFF_FFFF);
    writeCfg(REG_BASE0 + 4'd1, BASE1);
    finishTest("error", e);
  endtask

  // Memory model with a random acknowledge delay and completion 1 to 3 cycles later
  initial begin : busModel
    int phase;
    int waitCnt;
    int cmplCnt;
    logic [31:0] curAddr;
    phase     = 0;
    waitCnt   = 0;
    cmplCnt   = 0;
    curAddr   = '0;
    mstCmdAck = 1'b0;
    mstCmplt  = 1'b0;
    mstError  = 1'b0;
    mstRdData = '0;
    for (int i = 0; i < 256; i++) begin
      mem[i] = fillWord(8'(i));
    end
    forever begin
      @(negedge clk);
      if (!rst_n) begin
        phase     = 0;
        mstCmdAck = 1'b0;
        mstCmplt  = 1'b0;
        mstError  = 1'b0;
      end else begin
        case (phase)
          0: begin
            mstCmplt = 1'b0;
            mstError = 1'b0;
            if (mstRdReq || mstWrReq) begin
              curAddr = mstAddr;
              cmdAddrQ.push_back(mstAddr);
              cmdBeQ.push_back(mstBe);
              cmdDataQ.push_back(mstWrData);
              cmdWriteQ.push_back(mstWrReq);
              waitCnt = int'($unsigned($random(seed)) % 3) + extraAckDelay;
              phase = 1;
            end
          end
          1: begin
            if (waitCnt == 0) begin
              mstCmdAck = 1'b1;
              if (mstWrReq && curAddr < BAD_BASE) begin
                for (int b = 0; b < 4; b++) begin
                  if (mstBe[b]) mem[curAddr[9:2]][8 * b +: 8] = mstWrData[8 * b +: 8];
                end
              end
              cmplCnt = 1 + int'($unsigned($random(seed)) % 3);
              phase = 2;
            end else begin
              waitCnt--;
            end
          end
          default: begin
            mstCmdAck = 1'b0;
            cmplCnt--;
            if (cmplCnt == 0) begin
              mstCmplt  = 1'b1;
              mstRdData = mem[curAddr[9:2]];
              mstError  = (curAddr >= BAD_BASE);
              phase = 0;
            end
          end
        endcase
      end
    end
  end

  initial begin : watchdog
    cycles = 0;
    while (cycles < CYCLE_LIMIT) begin
      @(posedge clk);
      cycles++;
    end
    $display("run stopped after %0d cycles without finishing", cycles);
    $display("RESULT: FAIL");
    $finish;
  end

  initial begin
    seed          = 32'h8ecf_2911;
    errCount      = 0;
    testsRun      = 0;
    testsFailed   = 0;
    extraAckDelay = 0;
    nChipEnable   = '1;
    nOutputEnable = '1;
    nWriteEnable  = '1;
    for (int p = 0; p < NUM_PORTS; p++) begin
      address[p] = '0;
      dataIn[p]  = '0;
    end
    cfgWrite  = 1'b0;
    cfgAddr   = '0;
    cfgWrData = '0;
    @(posedge rst_n);
    testReset();
    testReadTranslation();
    testWrite();
    testInterrupts();
    testConcurrency();
    testError();
    $display("%0d tests run, %0d failed, %0d errors in %0d cycles",
             testsRun, testsFailed, errCount, cycles);
    if (errCount == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* compile.f */
hw/ttlBridgePkg.sv
hw/ttlWindowRegs.sv
hw/ttlPortBridge.sv
hw/busMasterArbiter.sv
hw/ttlBridgeTop.sv
testbench/tbClockGen.sv
testbench/tbTtlBridge.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert
TOP       := tbTtlBridge
FILELIST  := compile.f
OBJDIR    := obj_dir
LOG       := sim.log
PASS_MSG  := RESULT: PASS

SRCS := $(wildcard hw/*.sv testbench/*.sv)
BIN  := $(OBJDIR)/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN) | tee $(LOG)
	grep -qx "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJDIR) $(LOG)
